//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
+incdir+include
design/afu_pkg.sv
design/read_sequencer.sv
design/lane_multiplier.sv
design/line_fifo.sv
design/write_sequencer.sv
design/conv_lite_top.sv
dv/tb_clock.sv
dv/tb_top.sv

//--- design/afu_pkg.sv
`include "afu_consts.svh"

package afu_pkg;

  typedef logic [`CL_WIDTH-1:0]    cl_t;
  typedef logic [`ADDR_WIDTH-1:0]  addr_t;
  typedef logic [`MDATA_WIDTH-1:0] mdata_t;
  typedef logic [`LANE_WIDTH-1:0]  lane_t;

  // decoded job descriptor, addresses are cache-line addresses
  typedef struct packed {
    addr_t       image_addr;
    addr_t       kernel_addr;
    addr_t       dest_addr;
    logic [31:0] num_images;
  } job_t;

  // read request sequencing
  typedef enum logic [1:0] {
    IDLE,
    KERNEL,
    IMAGE,
    WAIT_DONE
  } rd_state_t;

endpackage

//--- design/conv_lite_top.sv
`timescale 1ns/100ps

module conv_lite_top (
  input  logic            clk,
  input  logic            reset,

  // read request
  output afu_pkg::addr_t  rd_req_addr,
  output afu_pkg::mdata_t rd_req_mdata,
  output logic            rd_req_en,
  input  logic            rd_req_almostfull,

  // read response
  input  logic            rd_rsp_valid,
  input  afu_pkg::mdata_t rd_rsp_mdata,
  input  afu_pkg::cl_t    rd_rsp_data,

  // write request
  output afu_pkg::addr_t  wr_req_addr,
  output afu_pkg::cl_t    wr_req_data,
  output logic            wr_req_en,
  input  logic            wr_req_almostfull,

  // control
  input  logic            start,
  input  afu_pkg::cl_t    afu_context,
  output logic            done
);
  import afu_pkg::*;

  job_t job;
  logic job_start;
  logic res_valid;
  cl_t  res_data;
  logic fifo_afull;
  logic fifo_empty;
  logic fifo_re;
  cl_t  fifo_dout;

  read_sequencer u_read_sequencer (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .afu_context       (afu_context),
    .rd_req_almostfull (rd_req_almostfull),
    .fifo_afull        (fifo_afull),
    .rd_req_addr       (rd_req_addr),
    .rd_req_mdata      (rd_req_mdata),
    .rd_req_en         (rd_req_en),
    .job               (job),
    .job_start         (job_start)
  );

  lane_multiplier u_lane_multiplier (
    .clk          (clk),
    .reset        (reset),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp_mdata (rd_rsp_mdata),
    .rd_rsp_data  (rd_rsp_data),
    .res_valid    (res_valid),
    .res_data     (res_data)
  );

  line_fifo u_line_fifo (
    .clk   (clk),
    .reset (reset),
    .we    (res_valid),
    .din   (res_data),
    .re    (fifo_re),
    .dout  (fifo_dout),
    .empty (fifo_empty),
    .afull (fifo_afull)
  );

  write_sequencer u_write_sequencer (
    .clk               (clk),
    .reset             (reset),
    .job               (job),
    .job_start         (job_start),
    .fifo_dout         (fifo_dout),
    .fifo_empty        (fifo_empty),
    .wr_req_almostfull (wr_req_almostfull),
    .fifo_re           (fifo_re),
    .wr_req_addr       (wr_req_addr),
    .wr_req_data       (wr_req_data),
    .wr_req_en         (wr_req_en),
    .done              (done)
  );

endmodule

//--- design/lane_multiplier.sv
`timescale 1ns/100ps
`include "afu_consts.svh"

module lane_multiplier (
  input  logic            clk,
  input  logic            reset,
  input  logic            rd_rsp_valid,
  input  afu_pkg::mdata_t rd_rsp_mdata,
  input  afu_pkg::cl_t    rd_rsp_data,
  output logic            res_valid,
  output afu_pkg::cl_t    res_data
);
  import afu_pkg::*;

  cl_t   kern_line;
  logic  is_kernel;
  logic  is_image;
  lane_t [`NUM_LANES-1:0] prod;

  // tag bit 0 separates kernel from image responses
  assign is_kernel = rd_rsp_valid && rd_rsp_mdata[0];
  assign is_image  = rd_rsp_valid && !rd_rsp_mdata[0];

  // lane by lane product, only the low 32 bits survive
  always_comb begin
    for (int i = 0; i < `NUM_LANES; i++) begin
      prod[i] = lane_t'(rd_rsp_data[i*`LANE_WIDTH +: `LANE_WIDTH])
              * lane_t'(kern_line[i*`LANE_WIDTH +: `LANE_WIDTH]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= is_image;
    end
  end

  always_ff @(posedge clk) begin
    if (is_kernel) begin
      kern_line <= rd_rsp_data;
    end
    if (is_image) begin
      res_data <= prod;
    end
  end

endmodule

//--- design/line_fifo.sv
`timescale 1ns/100ps
`include "afu_consts.svh"

module line_fifo #(
  parameter int DEPTH_BITS = `FIFO_DEPTH_BITS
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         we,
  input  afu_pkg::cl_t din,
  input  logic         re,
  output afu_pkg::cl_t dout,
  output logic         empty,
  output logic         afull
);
  import afu_pkg::*;

  localparam int DEPTH = 2 ** DEPTH_BITS;

  cl_t                   mem [DEPTH];
  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic [DEPTH_BITS:0]   count;
  logic                  full;

  assign empty = (count == 0);
  assign full  = (count == (DEPTH_BITS+1)'(DEPTH));
  assign afull = (count >= (DEPTH_BITS+1)'(`FIFO_AFULL_LEVEL));

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (we) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (re) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({we, re})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // registered pop, dout follows re by one cycle
  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_ptr] <= din;
    end
    if (re) begin
      dout <= mem[rd_ptr];
    end
  end

  assert property (@(posedge clk) disable iff (reset) we |-> !full);
  assert property (@(posedge clk) disable iff (reset) re |-> !empty);

endmodule

//--- design/read_sequencer.sv
`timescale 1ns/100ps
`include "afu_consts.svh"

module read_sequencer (
  input  logic            clk,
  input  logic            reset,
  input  logic            start,
  input  afu_pkg::cl_t    afu_context,
  input  logic            rd_req_almostfull,
  input  logic            fifo_afull,
  output afu_pkg::addr_t  rd_req_addr,
  output afu_pkg::mdata_t rd_req_mdata,
  output logic            rd_req_en,
  output afu_pkg::job_t   job,
  output logic            job_start
);
  import afu_pkg::*;

  // bits 5:0 of a byte address select the byte within a line
  localparam int LINE_SHIFT = 6;

  rd_state_t   state;
  job_t        ctx_job;
  addr_t       img_addr;
  logic [31:0] img_left;
  logic        take_start;
  logic        kernel_go;
  logic        image_go;

  always_comb begin
    ctx_job.image_addr  = afu_context[`CTX_IMAGE_LSB+LINE_SHIFT +: `ADDR_WIDTH];
    ctx_job.kernel_addr = afu_context[`CTX_KERNEL_LSB+LINE_SHIFT +: `ADDR_WIDTH];
    ctx_job.dest_addr   = afu_context[`CTX_DEST_LSB+LINE_SHIFT +: `ADDR_WIDTH];
    ctx_job.num_images  = afu_context[`CTX_COUNT_LSB +: 32];
  end

  // a new job is accepted only when no job is in flight
  assign take_start = start && (state == IDLE || state == WAIT_DONE);
  assign kernel_go  = (state == KERNEL) && !rd_req_almostfull;
  // image lines also wait for room in the result FIFO
  assign image_go   = (state == IMAGE) && !rd_req_almostfull && !fifo_afull;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= IDLE;
      rd_req_en <= 1'b0;
      job_start <= 1'b0;
      img_left  <= '0;
    end else begin
      job_start <= take_start;
      rd_req_en <= kernel_go || image_go;
      if (take_start) begin
        img_left <= ctx_job.num_images;
        state    <= KERNEL;
      end else if (kernel_go) begin
        state <= (job.num_images == 0) ? WAIT_DONE : IMAGE;
      end else if (image_go) begin
        img_left <= img_left - 1;
        if (img_left == 1) begin
          state <= WAIT_DONE;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_start) begin
      job      <= ctx_job;
      img_addr <= ctx_job.image_addr;
    end
    if (kernel_go) begin
      rd_req_addr  <= job.kernel_addr;
      rd_req_mdata <= mdata_t'(1);
    end else if (image_go) begin
      rd_req_addr  <= img_addr;
      rd_req_mdata <= '0;
      img_addr     <= img_addr + 1'b1;
    end
  end

  // the request port must see almostfull before the next request goes out
  assert property (@(posedge clk) disable iff (reset)
    $past(rd_req_almostfull) |-> !rd_req_en);

endmodule

//--- design/write_sequencer.sv
`timescale 1ns/100ps

module write_sequencer (
  input  logic           clk,
  input  logic           reset,
  input  afu_pkg::job_t  job,
  input  logic           job_start,
  input  afu_pkg::cl_t   fifo_dout,
  input  logic           fifo_empty,
  input  logic           wr_req_almostfull,
  output logic           fifo_re,
  output afu_pkg::addr_t wr_req_addr,
  output afu_pkg::cl_t   wr_req_data,
  output logic           wr_req_en,
  output logic           done
);
  import afu_pkg::*;

  addr_t       next_addr;
  logic [31:0] wr_cnt;
  logic        last_write;

  // pop whenever a line is waiting and the write port has room
  assign fifo_re = !fifo_empty && !wr_req_almostfull;

  // the popped line shows up on dout in the same cycle as wr_req_en
  assign wr_req_data = fifo_dout;

  assign last_write = wr_req_en && (wr_cnt == job.num_images - 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_req_en <= 1'b0;
      wr_cnt    <= '0;
      next_addr <= '0;
      done      <= 1'b0;
    end else begin
      wr_req_en <= fifo_re;
      if (job_start) begin
        wr_cnt    <= '0;
        next_addr <= job.dest_addr;
        done      <= 1'b0;
      end else begin
        if (fifo_re) begin
          next_addr <= next_addr + 1'b1;
        end
        if (wr_req_en) begin
          wr_cnt <= wr_cnt + 1;
        end
        // done holds until the next job starts
        if (last_write) begin
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_re) begin
      wr_req_addr <= next_addr;
    end
  end

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
  parameter real PERIOD = 40.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2.0) clk = ~clk;
  end

endmodule

//--- dv/tb_top.sv
`timescale 1ns/100ps
`include "afu_consts.svh"

module tb_top;
  import afu_pkg::*;

  localparam int NUM_JOBS  = 3;
  // memory answers this many cycles after the request edge
  localparam int RSP_DELAY = 3;

  logic   clk;
  logic   reset;
  addr_t  rd_req_addr;
  mdata_t rd_req_mdata;
  logic   rd_req_en;
  logic   rd_req_almostfull;
  logic   rd_rsp_valid;
  mdata_t rd_rsp_mdata;
  cl_t    rd_rsp_data;
  addr_t  wr_req_addr;
  cl_t    wr_req_data;
  logic   wr_req_en;
  logic   wr_req_almostfull;
  logic   start;
  cl_t    afu_context;
  logic   done;

  cl_t    mem [addr_t];
  addr_t  exp_rd_addr [$];
  mdata_t exp_rd_tag [$];
  addr_t  exp_wr_addr [$];
  cl_t    exp_wr_data [$];
  logic   pipe_valid [RSP_DELAY-1];
  addr_t  pipe_addr [RSP_DELAY-1];
  mdata_t pipe_tag [RSP_DELAY-1];
  int     num_img [NUM_JOBS];
  string  test_name = "reset";
  int     err_count = 0;
  int     check_count = 0;
  int     since_start = 1000;
  int     limit_cycles = 0;
  logic   prev_done = 1'b0;
  logic   job_live = 1'b0;

  tb_clock u_clock (.clk(clk));

  conv_lite_top DUT (.*);

  function automatic cl_t random_line();
    cl_t line;
    for (int i = 0; i < `NUM_LANES; i++) begin
      line[i*`LANE_WIDTH +: `LANE_WIDTH] = $urandom;
    end
    return line;
  endfunction

  // untouched lines read back as a copy of their own address
  function automatic cl_t read_line(addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return {8{6'b0, a}};
  endfunction

  // reference result, each lane product cut to 32 bits
  function automatic cl_t lane_product(cl_t img, cl_t kern);
    cl_t   res;
    lane_t a;
    lane_t b;
    for (int i = 0; i < `NUM_LANES; i++) begin
      a = img[i*`LANE_WIDTH +: `LANE_WIDTH];
      b = kern[i*`LANE_WIDTH +: `LANE_WIDTH];
      res[i*`LANE_WIDTH +: `LANE_WIDTH] = a * b;
    end
    return res;
  endfunction

  task automatic check_value(string name, cl_t expected, cl_t actual);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("ERROR %s %s: expected %0h, actual %0h", test_name, name, expected, actual);
    end
  endtask

  task automatic report_fault(string msg);
    err_count++;
    $display("ERROR: %s in %s at %0t", msg, test_name, $time);
  endtask

  // almostfull seen here is the value the DUT sampled at the last edge
  task automatic check_read_port();
    if (rd_req_en && rd_req_almostfull) begin
      report_fault("read request issued while rd_req_almostfull was high");
    end
    if (rd_req_en) begin
      if (exp_rd_addr.size() == 0) begin
        report_fault("unexpected read request");
      end else begin
        check_value("read_addr", cl_t'(exp_rd_addr.pop_front()), cl_t'(rd_req_addr));
        check_value("read_tag", cl_t'(exp_rd_tag.pop_front()), cl_t'(rd_req_mdata));
      end
    end
  endtask

  task automatic check_write_port();
    if (wr_req_en && wr_req_almostfull) begin
      report_fault("write request issued while wr_req_almostfull was high");
    end
    if (wr_req_en) begin
      if (exp_wr_addr.size() == 0) begin
        report_fault("unexpected write request");
      end else begin
        check_value("write_addr", cl_t'(exp_wr_addr.pop_front()), cl_t'(wr_req_addr));
        check_value("write_data", exp_wr_data.pop_front(), wr_req_data);
      end
    end
  endtask

  // done must drop two edges after start and rise only once all writes are out
  task automatic check_done_level();
    if (start) begin
      since_start = 0;
      job_live = 1'b1;
    end else if (since_start < 1000) begin
      since_start++;
    end
    if (since_start == 1 && done) begin
      report_fault("done did not fall after start");
    end
    if (prev_done && !done && since_start != 1) begin
      report_fault("done fell without a new start");
    end
    if (done && !prev_done && !job_live) begin
      report_fault("done rose with no job running");
    end
    if (done && job_live && since_start >= 2) begin
      if (exp_wr_addr.size() != 0) begin
        report_fault("done rose before the last write");
      end
      job_live = 1'b0;
    end
    prev_done = done;
  endtask

  task automatic drive_response();
    rd_rsp_valid <= pipe_valid[RSP_DELAY-2];
    rd_rsp_mdata <= pipe_tag[RSP_DELAY-2];
    rd_rsp_data  <= pipe_valid[RSP_DELAY-2] ? read_line(pipe_addr[RSP_DELAY-2]) : '0;
    for (int k = RSP_DELAY-2; k > 0; k--) begin
      pipe_valid[k] = pipe_valid[k-1];
      pipe_addr[k]  = pipe_addr[k-1];
      pipe_tag[k]   = pipe_tag[k-1];
    end
    pipe_valid[0] = rd_req_en;
    pipe_addr[0]  = rd_req_addr;
    pipe_tag[0]   = rd_req_mdata;
  endtask

  // memory model, back-pressure and port checks
  always @(negedge clk) begin
    if (reset) begin
      rd_rsp_valid      <= 1'b0;
      rd_req_almostfull <= 1'b0;
      wr_req_almostfull <= 1'b0;
      for (int k = 0; k < RSP_DELAY-1; k++) begin
        pipe_valid[k] = 1'b0;
      end
    end else begin
      check_read_port();
      check_write_port();
      check_done_level();
      drive_response();
      // roughly one cycle in four is stalled
      rd_req_almostfull <= ($urandom % 4) == 0;
      wr_req_almostfull <= ($urandom % 4) == 0;
    end
  end

  task automatic run_job(int idx);
    addr_t kern;
    addr_t img;
    addr_t dest;
    cl_t   ctx;
    test_name = $sformatf("job%0d", idx);
    kern = addr_t'({$urandom, $urandom});
    img  = addr_t'({$urandom, $urandom});
    dest = addr_t'({$urandom, $urandom});
    mem[kern] = random_line();
    for (int i = 0; i < num_img[idx]; i++) begin
      mem[img + addr_t'(i)] = random_line();
    end
    exp_rd_addr.push_back(kern);
    exp_rd_tag.push_back(mdata_t'(1));
    for (int i = 0; i < num_img[idx]; i++) begin
      exp_rd_addr.push_back(img + addr_t'(i));
      exp_rd_tag.push_back('0);
      exp_wr_addr.push_back(dest + addr_t'(i));
      exp_wr_data.push_back(lane_product(mem[img + addr_t'(i)], mem[kern]));
    end
    // byte addresses, the low six bits only pick a byte inside the line
    ctx = '0;
    ctx[`CTX_IMAGE_LSB +: 64]  = {img, 6'($urandom)};
    ctx[`CTX_DEST_LSB +: 64]   = {dest, 6'($urandom)};
    ctx[`CTX_KERNEL_LSB +: 64] = {kern, 6'($urandom)};
    ctx[`CTX_COUNT_LSB +: 32]  = 32'(num_img[idx]);
    @(negedge clk);
    start       <= 1'b1;
    afu_context <= ctx;
    @(negedge clk);
    start <= 1'b0;
    @(negedge clk);
    while (!done) begin
      @(negedge clk);
    end
    // a few idle cycles catch any write after done
    repeat (8) @(negedge clk);
    if (exp_rd_addr.size() != 0) begin
      report_fault($sformatf("%0d read requests never issued", exp_rd_addr.size()));
    end
    if (exp_wr_addr.size() != 0) begin
      report_fault($sformatf("%0d writes never issued", exp_wr_addr.size()));
    end
    exp_rd_addr.delete();
    exp_rd_tag.delete();
    exp_wr_addr.delete();
    exp_wr_data.delete();
  endtask

  initial begin
    int total;
    void'($urandom(32'h4cc6));
    reset             = 1'b1;
    start             = 1'b0;
    afu_context       = '0;
    rd_req_almostfull = 1'b0;
    wr_req_almostfull = 1'b0;
    rd_rsp_valid      = 1'b0;
    rd_rsp_mdata      = '0;
    rd_rsp_data       = '0;
    total = 0;
    for (int j = 0; j < NUM_JOBS; j++) begin
      num_img[j] = 1 + int'($urandom % 40);
      total += num_img[j];
    end
    limit_cycles = 500 + 200 * total;
    repeat (2) @(negedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_count++;
    if (done !== 1'b0) begin
      report_fault("done not low after reset");
    end
    for (int j = 0; j < NUM_JOBS; j++) begin
      run_job(j);
    end
    $display("checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("ERROR: run did not finish within %0d cycles", limit_cycles);
    $display("checks %0d, errors %0d", check_count, err_count + 1);
    $display("Test failed");
    $finish;
  end

endmodule

//--- include/afu_consts.svh
`ifndef AFU_CONSTS_SVH
`define AFU_CONSTS_SVH

// cache line and request fields
`define CL_WIDTH      512
`define ADDR_WIDTH    58
`define MDATA_WIDTH   14

// datapath lanes
`define LANE_WIDTH    32
`define NUM_LANES     16

// result FIFO, image reads pause at half full
`define FIFO_DEPTH_BITS   4
`define FIFO_AFULL_LEVEL  8

// context word field offsets, address fields are byte addresses
`define CTX_IMAGE_LSB   64
`define CTX_DEST_LSB    128
`define CTX_COUNT_LSB   192
`define CTX_KERNEL_LSB  256

`endif
